//--- src/accq_pkg.sv
// accumulator bank package: sizes, stream beats, command format and FSM states
package accq_pkg;

  // ==================================================
  // sizes
  // ==================================================
  localparam int unsigned NUM_ACC = 8;  // accumulators in the bank
  localparam int unsigned ACC_W   = 32; // accumulator and psum width
  localparam int unsigned QNT_W   = 8;  // quantized output width
  localparam int unsigned SCALE_W = 8;  // unsigned scale
  localparam int unsigned SHIFT_W = 5;  // right shift amount
  localparam int unsigned ADDR_W  = 3;  // accumulator address
  localparam int unsigned LEN_W   = 8;  // command length field

  // signed product of accumulator and zero-extended scale
  localparam int unsigned PROD_W = ACC_W + SCALE_W + 1;

  // saturation bounds of the quantized result
  localparam int Q_MAX = (2 ** (QNT_W - 1)) - 1;
  localparam int Q_MIN = -(2 ** (QNT_W - 1));

  // ==================================================
  // data types
  // ==================================================
  typedef logic signed [ACC_W-1:0] acc_t;

  typedef struct packed {
    acc_t value;  // one partial sum
  } psum_beat_t;

  typedef struct packed {
    logic [SCALE_W-1:0] scale;
    logic [SHIFT_W-1:0] shift;
  } norm_beat_t;

  typedef enum logic [1:0] {
    OP_CLEAR,
    OP_ACCUM,
    OP_NORMQUANT,
    OP_STREAMOUT
  } op_e;

  typedef struct packed {
    op_e              op;
    logic [LEN_W-1:0] len;  // psum beats, accumulate only
  } cmd_t;

  // request into the normquant pipeline
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    acc_t               acc;
    logic [SCALE_W-1:0] scale;
    logic [SHIFT_W-1:0] shift;
  } nq_req_t;

  // quantized result on its way back to the bank
  typedef struct packed {
    logic [ADDR_W-1:0]       addr;
    logic signed [QNT_W-1:0] q;
  } nq_rsp_t;

  typedef logic [NUM_ACC*QNT_W-1:0] out_beat_t;  // byte i holds accumulator i

  typedef enum logic [2:0] {
    IDLE,
    ACCUM,
    NQ_ISSUE,
    NQ_DRAIN,
    STREAMOUT
  } state_e;

endpackage

//--- src/accq_fifo.sv
// two-entry valid/ready FIFO, payload type set by parameter
module accq_fifo #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // input stream
  input  logic in_valid_i,
  input  T     in_data_i,
  output logic in_ready_o,
  // output stream
  output logic out_valid_o,
  output T     out_data_o,
  input  logic out_ready_i
);

  T           mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

//--- src/accq_bank.sv
// accumulator register file with add port, quantized write-back and clear
module accq_bank (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      clear_i,
  // accumulate port
  input  logic                                      add_en_i,
  input  logic [accq_pkg::ADDR_W-1:0]               add_addr_i,
  input  accq_pkg::acc_t                            add_val_i,
  // quantized write-back port
  input  logic                                      wr_en_i,
  input  logic [accq_pkg::ADDR_W-1:0]               wr_addr_i,
  input  logic signed [accq_pkg::QNT_W-1:0]         wr_q_i,
  // read ports
  input  logic [accq_pkg::ADDR_W-1:0]               rd_addr_i,
  output accq_pkg::acc_t                            rd_data_o,
  output accq_pkg::acc_t [accq_pkg::NUM_ACC-1:0]    all_o
);

  accq_pkg::acc_t [accq_pkg::NUM_ACC-1:0] acc_q;
  accq_pkg::acc_t                         sum;
  accq_pkg::acc_t                         wr_ext;

  // ==================================================
  // datapath
  // ==================================================
  assign sum    = acc_q[add_addr_i] + add_val_i;  // wraps at 32 bits
  assign wr_ext = {{(accq_pkg::ACC_W - accq_pkg::QNT_W){wr_q_i[accq_pkg::QNT_W-1]}}, wr_q_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else begin
      if (add_en_i) begin
        acc_q[add_addr_i] <= sum;
      end
      // write-back wins if both hit the same entry
      if (wr_en_i) begin
        acc_q[wr_addr_i] <= wr_ext;
      end
    end
  end

  // ==================================================
  // read side
  // ==================================================
  assign rd_data_o = acc_q[rd_addr_i];  // combinational read
  assign all_o     = acc_q;             // whole bank for streamout

endmodule

//--- src/accq_normquant.sv
// normalization and quantization stage: scale, arithmetic shift, saturate to 8 bits
module accq_normquant (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  accq_pkg::nq_req_t req_i,
  output logic              rsp_valid_o,
  output accq_pkg::nq_rsp_t rsp_o
);

  logic signed [accq_pkg::PROD_W-1:0] prod;
  logic signed [accq_pkg::PROD_W-1:0] shifted;
  logic signed [accq_pkg::QNT_W-1:0]  q_d;
  logic                               rsp_valid_q;
  accq_pkg::nq_rsp_t                  rsp_q;

  // scale is unsigned, so it gets a zero sign bit
  assign prod    = req_i.acc * $signed({1'b0, req_i.scale});
  assign shifted = prod >>> req_i.shift;

  // clip to the signed 8-bit range
  always_comb begin
    if (shifted > accq_pkg::Q_MAX) begin
      q_d = accq_pkg::QNT_W'(accq_pkg::Q_MAX);
    end else if (shifted < accq_pkg::Q_MIN) begin
      q_d = accq_pkg::QNT_W'(accq_pkg::Q_MIN);
    end else begin
      q_d = shifted[accq_pkg::QNT_W-1:0];
    end
  end

  // one pipeline register, never stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q.addr <= req_i.addr;
      rsp_q.q    <= q_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- src/accq_ctrl.sv
// command FSM with length and address counters and the stream handshakes
module accq_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // commands
  input  logic                          cmd_valid_i,
  input  accq_pkg::cmd_t                cmd_i,
  output logic                          cmd_ready_o,
  // psum and norm streams from the FIFOs
  input  logic                          psum_valid_i,
  input  accq_pkg::psum_beat_t          psum_i,
  output logic                          psum_ready_o,
  input  logic                          norm_valid_i,
  input  accq_pkg::norm_beat_t          norm_i,
  output logic                          norm_ready_o,
  // bank
  input  accq_pkg::acc_t                rd_data_i,
  output logic                          bank_clear_o,
  output logic                          add_en_o,
  output logic [accq_pkg::ADDR_W-1:0]   add_addr_o,
  output accq_pkg::acc_t                add_val_o,
  output logic [accq_pkg::ADDR_W-1:0]   rd_addr_o,
  // normquant pipeline
  output logic                          nq_valid_o,
  output accq_pkg::nq_req_t             nq_req_o,
  // output register
  output logic                          out_load_o,
  input  logic                          out_ready_i,
  output logic                          busy_o
);

  accq_pkg::state_e                state_q, state_d;
  logic [accq_pkg::LEN_W-1:0]      len_q;
  logic [accq_pkg::ADDR_W-1:0]     addr_q;
  logic                            cmd_hs;
  logic                            psum_hs;
  logic                            norm_hs;
  logic                            addr_last;

  assign cmd_ready_o  = (state_q == accq_pkg::IDLE);
  assign busy_o       = (state_q != accq_pkg::IDLE);
  assign psum_ready_o = (state_q == accq_pkg::ACCUM);
  assign norm_ready_o = (state_q == accq_pkg::NQ_ISSUE);

  assign cmd_hs    = cmd_valid_i & cmd_ready_o;
  assign psum_hs   = psum_valid_i & psum_ready_o;
  assign norm_hs   = norm_valid_i & norm_ready_o;
  assign addr_last = (addr_q == accq_pkg::ADDR_W'(accq_pkg::NUM_ACC - 1));

  // ==================================================
  // bank and pipeline controls
  // ==================================================
  assign bank_clear_o = cmd_hs & (cmd_i.op == accq_pkg::OP_CLEAR);
  assign out_load_o   = cmd_hs & (cmd_i.op == accq_pkg::OP_STREAMOUT);

  assign add_en_o   = psum_hs;
  assign add_addr_o = addr_q;
  assign add_val_o  = psum_i.value;

  assign rd_addr_o  = addr_q;
  assign nq_valid_o = norm_hs;  // one request per norm beat

  always_comb begin
    nq_req_o.addr  = addr_q;
    nq_req_o.acc   = rd_data_i;
    nq_req_o.scale = norm_i.scale;
    nq_req_o.shift = norm_i.shift;
  end

  // ==================================================
  // FSM
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      accq_pkg::IDLE: begin
        if (cmd_hs) begin
          case (cmd_i.op)
            accq_pkg::OP_ACCUM:     if (cmd_i.len != '0) state_d = accq_pkg::ACCUM;
            accq_pkg::OP_NORMQUANT: state_d = accq_pkg::NQ_ISSUE;
            accq_pkg::OP_STREAMOUT: state_d = accq_pkg::STREAMOUT;
            default:                state_d = accq_pkg::IDLE;  // clear is done in place
          endcase
        end
      end
      accq_pkg::ACCUM: begin
        if (psum_hs && len_q == accq_pkg::LEN_W'(1)) state_d = accq_pkg::IDLE;
      end
      accq_pkg::NQ_ISSUE: begin
        if (norm_hs && addr_last) state_d = accq_pkg::NQ_DRAIN;
      end
      accq_pkg::NQ_DRAIN:  state_d = accq_pkg::IDLE;  // last write-back lands here
      accq_pkg::STREAMOUT: begin
        if (out_ready_i) state_d = accq_pkg::IDLE;    // out_valid_o is high all along
      end
      default: state_d = accq_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= accq_pkg::IDLE;
      len_q   <= '0;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      // remaining psum beats of an accumulate
      if (cmd_hs && cmd_i.op == accq_pkg::OP_ACCUM) begin
        len_q <= cmd_i.len;
      end else if (psum_hs) begin
        len_q <= len_q - 1'b1;
      end
      // round-robin address, restarts only for normquant
      if (cmd_hs && cmd_i.op == accq_pkg::OP_NORMQUANT) begin
        addr_q <= '0;
      end else if (psum_hs || norm_hs) begin
        addr_q <= addr_last ? '0 : addr_q + 1'b1;
      end
    end
  end

endmodule

//--- src/accq_top.sv
// accumulator bank top: input FIFOs, controller, bank, normquant and streamout register
module accq_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // command stream
  input  logic                 cmd_valid_i,
  input  accq_pkg::cmd_t       cmd_i,
  output logic                 cmd_ready_o,
  // psum stream
  input  logic                 psum_valid_i,
  input  accq_pkg::psum_beat_t psum_i,
  output logic                 psum_ready_o,
  // norm stream
  input  logic                 norm_valid_i,
  input  accq_pkg::norm_beat_t norm_i,
  output logic                 norm_ready_o,
  // output stream
  output logic                 out_valid_o,
  output accq_pkg::out_beat_t  out_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  logic                                   psum_f_valid, psum_f_ready;
  accq_pkg::psum_beat_t                   psum_f;
  logic                                   norm_f_valid, norm_f_ready;
  accq_pkg::norm_beat_t                   norm_f;
  logic                                   bank_clear, add_en;
  logic [accq_pkg::ADDR_W-1:0]            add_addr, rd_addr;
  accq_pkg::acc_t                         add_val, rd_data;
  accq_pkg::acc_t [accq_pkg::NUM_ACC-1:0] all_acc;
  logic                                   nq_valid, rsp_valid;
  accq_pkg::nq_req_t                      nq_req;
  accq_pkg::nq_rsp_t                      nq_rsp;
  logic                                   out_load;
  logic                                   out_valid_q;
  accq_pkg::out_beat_t                    out_q, packed_bytes;

  // ==================================================
  // input side
  // ==================================================
  accq_fifo #(.T(accq_pkg::psum_beat_t)) u_psum_fifo (
    .clk_i, .rst_ni,
    .in_valid_i (psum_valid_i), .in_data_i (psum_i), .in_ready_o (psum_ready_o),
    .out_valid_o(psum_f_valid), .out_data_o(psum_f), .out_ready_i(psum_f_ready)
  );

  accq_fifo #(.T(accq_pkg::norm_beat_t)) u_norm_fifo (
    .clk_i, .rst_ni,
    .in_valid_i (norm_valid_i), .in_data_i (norm_i), .in_ready_o (norm_ready_o),
    .out_valid_o(norm_f_valid), .out_data_o(norm_f), .out_ready_i(norm_f_ready)
  );

  // ==================================================
  // processing
  // ==================================================
  accq_ctrl u_ctrl (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_i, .cmd_ready_o,
    .psum_valid_i(psum_f_valid), .psum_i(psum_f), .psum_ready_o(psum_f_ready),
    .norm_valid_i(norm_f_valid), .norm_i(norm_f), .norm_ready_o(norm_f_ready),
    .rd_data_i(rd_data), .bank_clear_o(bank_clear), .add_en_o(add_en),
    .add_addr_o(add_addr), .add_val_o(add_val), .rd_addr_o(rd_addr),
    .nq_valid_o(nq_valid), .nq_req_o(nq_req), .out_load_o(out_load),
    .out_ready_i, .busy_o
  );

  accq_bank u_bank (
    .clk_i, .rst_ni, .clear_i(bank_clear),
    .add_en_i(add_en), .add_addr_i(add_addr), .add_val_i(add_val),
    .wr_en_i(rsp_valid), .wr_addr_i(nq_rsp.addr), .wr_q_i(nq_rsp.q),  // write-back
    .rd_addr_i(rd_addr), .rd_data_o(rd_data), .all_o(all_acc)
  );

  accq_normquant u_nq (
    .clk_i, .rst_ni, .req_valid_i(nq_valid), .req_i(nq_req),
    .rsp_valid_o(rsp_valid), .rsp_o(nq_rsp)
  );

  // ==================================================
  // streamout register
  // ==================================================
  always_comb begin
    for (int i = 0; i < accq_pkg::NUM_ACC; i++) begin
      packed_bytes[i*accq_pkg::QNT_W +: accq_pkg::QNT_W] = all_acc[i][accq_pkg::QNT_W-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (out_load) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;  // beat taken
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_load) out_q <= packed_bytes;
  end

  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;

endmodule

//--- testbench/tb_clock.sv
// testbench clock source with a period of 4 time units
module tb_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;  // half period
    end
  end

endmodule

//--- testbench/accq_tb.sv
// testbench for the accumulator bank with stimulus, reference model and output checker
module accq_tb;

  localparam int TIMEOUT = 500;  // cycles allowed for any single wait

  logic                 clk;
  logic                 rst_ni;
  logic                 cmd_valid_i;
  accq_pkg::cmd_t       cmd_i;
  logic                 cmd_ready_o;
  logic                 psum_valid_i;
  accq_pkg::psum_beat_t psum_i;
  logic                 psum_ready_o;
  logic                 norm_valid_i;
  accq_pkg::norm_beat_t norm_i;
  logic                 norm_ready_o;
  logic                 out_valid_o;
  accq_pkg::out_beat_t  out_o;
  logic                 out_ready_i = 1'b1;
  logic                 busy_o;

  // reference model state
  accq_pkg::acc_t       model [accq_pkg::NUM_ACC];
  int unsigned          ptr;          // round-robin accumulate address
  accq_pkg::out_beat_t  exp_q [$];    // expected beats, one per streamout
  int unsigned          n_stream;
  int unsigned          n_beats;
  logic                 bp_en;        // random back-pressure on out_ready_i
  logic                 held;         // beat was stalled at the last edge
  accq_pkg::out_beat_t  held_beat;
  accq_pkg::out_beat_t  exp_beat;

  tb_clock u_clk (.clk_o(clk));

  accq_top uut (
    .clk_i       (clk),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .psum_valid_i(psum_valid_i),
    .psum_i      (psum_i),
    .psum_ready_o(psum_ready_o),
    .norm_valid_i(norm_valid_i),
    .norm_i      (norm_i),
    .norm_ready_o(norm_ready_o),
    .out_valid_o (out_valid_o),
    .out_o       (out_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  // ==================================================
  // reference model
  // ==================================================
  function automatic void ref_accumulate(input accq_pkg::acc_t v);
    model[ptr] = model[ptr] + v;  // wraps at 32 bits
    ptr = (ptr + 1) % accq_pkg::NUM_ACC;
  endfunction

  function automatic accq_pkg::acc_t ref_quant(input accq_pkg::acc_t acc,
                                               input logic [accq_pkg::SCALE_W-1:0] scale,
                                               input logic [accq_pkg::SHIFT_W-1:0] shift);
    longint p;
    p = longint'(acc) * longint'(scale);  // scale is unsigned
    p = p >>> shift;
    if (p > 127) begin
      p = 127;
    end else if (p < -128) begin
      p = -128;
    end
    return accq_pkg::acc_t'(p);
  endfunction

  function automatic accq_pkg::out_beat_t ref_pack();
    accq_pkg::out_beat_t b;
    for (int i = 0; i < accq_pkg::NUM_ACC; i++) begin
      b[i*accq_pkg::QNT_W +: accq_pkg::QNT_W] = model[i][accq_pkg::QNT_W-1:0];
    end
    return b;
  endfunction

  // mode 1 gives large values of alternating sign and mode 2 small ones
  function automatic accq_pkg::acc_t rand_psum(input int mode);
    int mag;
    mag = int'($urandom_range(32'h3fff_ffff, 32'h0010_0000));
    case (mode)
      1:       return (ptr % 2 == 0) ? mag : -mag;
      2:       return int'($urandom_range(2000, 0)) - 1000;
      default: return $urandom();
    endcase
  endfunction

  // ==================================================
  // stimulus tasks entered on a falling edge
  // ==================================================
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    assert (actual === expected)
      else report_failure($sformatf("[ERROR] t=%0t %s: expected %0b actual %0b",
                                    $time, name, expected, actual));
  endtask

  task automatic send_cmd(input accq_pkg::op_e op, input int len);
    int n;
    n = 0;
    cmd_valid_i = 1'b1;
    cmd_i.op    = op;
    cmd_i.len   = accq_pkg::LEN_W'(len);
    while (!cmd_ready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_failure("timeout: command was never accepted");
    end
    if (op == accq_pkg::OP_STREAMOUT) begin
      exp_q.push_back(ref_pack());
      n_stream++;
    end
    @(negedge clk);  // transfer on the rising edge in between
    cmd_valid_i = 1'b0;
  endtask

  task automatic send_psum(input accq_pkg::acc_t v);
    int n;
    n = 0;
    psum_valid_i = 1'b1;
    psum_i.value = v;
    while (!psum_ready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_failure("timeout: psum FIFO never accepted a beat");
    end
    @(negedge clk);
    psum_valid_i = 1'b0;
  endtask

  task automatic send_norm(input logic [accq_pkg::SCALE_W-1:0] scale,
                           input logic [accq_pkg::SHIFT_W-1:0] shift);
    int n;
    n = 0;
    norm_valid_i = 1'b1;
    norm_i.scale = scale;
    norm_i.shift = shift;
    while (!norm_ready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_failure("timeout: norm FIFO never accepted a beat");
    end
    @(negedge clk);
    norm_valid_i = 1'b0;
  endtask

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while (busy_o || !cmd_ready_o) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_failure({"timeout: DUT stayed busy during ", what});
    end
  endtask

  task automatic do_clear();
    send_cmd(accq_pkg::OP_CLEAR, 0);
    for (int i = 0; i < accq_pkg::NUM_ACC; i++) begin
      model[i] = '0;
    end
    wait_idle("clear");
  endtask

  // the first two beats of a longer burst wait in the psum FIFO for the command
  task automatic do_accumulate(input int len, input int mode);
    accq_pkg::acc_t v;
    int             pre;
    pre = (len >= 2) ? 2 : 0;
    for (int i = 0; i < pre; i++) begin
      v = rand_psum(mode);
      send_psum(v);
      ref_accumulate(v);
    end
    if (pre == 2) begin
      check_bit("psum_ready_o", psum_ready_o, 1'b0);  // full while the DUT is idle
    end
    send_cmd(accq_pkg::OP_ACCUM, len);
    for (int i = pre; i < len; i++) begin
      v = rand_psum(mode);
      send_psum(v);
      ref_accumulate(v);
      repeat ($urandom_range(2, 0)) @(negedge clk);  // random input gap
    end
    wait_idle("accumulate");
  endtask

  // the first two beats force saturation when force_sat is set
  task automatic do_normquant(input bit force_sat);
    logic [accq_pkg::SCALE_W-1:0] scale;
    logic [accq_pkg::SHIFT_W-1:0] shift;
    ptr = 0;  // address restarts at 0 and wraps back to it after the pass
    for (int i = 0; i < accq_pkg::NUM_ACC; i++) begin
      scale = accq_pkg::SCALE_W'($urandom());
      shift = accq_pkg::SHIFT_W'($urandom());
      if (force_sat && i < 2) begin
        scale = '1;
        shift = '0;
      end
      // two beats are queued in the norm FIFO before the command
      if (i == 2) begin
        check_bit("norm_ready_o", norm_ready_o, 1'b0);
        send_cmd(accq_pkg::OP_NORMQUANT, 0);
      end
      send_norm(scale, shift);
      model[i] = ref_quant(model[i], scale, shift);
    end
    wait_idle("normquant");
  endtask

  task automatic do_streamout();
    send_cmd(accq_pkg::OP_STREAMOUT, 0);
    wait_idle("streamout");
    assert (n_beats == n_stream && !out_valid_o)
      else report_failure("streamout did not deliver exactly one beat");
  endtask

  // ==================================================
  // output side with back-pressure and checker
  // ==================================================
  always @(negedge clk) begin
    if (bp_en) out_ready_i = ($urandom_range(2, 0) == 0);
    else out_ready_i = 1'b1;
  end

  always @(posedge clk) begin
    if (rst_ni) begin
      if (held) begin
        assert (out_valid_o) else report_failure("out_valid_o dropped before the beat was taken");
        assert (out_o == held_beat)
          else report_failure($sformatf("[ERROR] t=%0t out_o not stable: expected %h actual %h",
                                        $time, held_beat, out_o));
      end
      if (out_valid_o) begin
        assert (busy_o) else report_failure("busy_o low while an out beat is pending");
      end
      if (out_valid_o && out_ready_i) begin
        assert (exp_q.size() > 0) else report_failure("out beat without a streamout command");
        exp_beat = exp_q.pop_front();
        assert (out_o == exp_beat)
          else report_failure($sformatf("[ERROR] t=%0t out_o: expected %h actual %h",
                                        $time, exp_beat, out_o));
        n_beats++;
        held = 1'b0;
      end else begin
        held      = out_valid_o;  // stalled beat must hold
        held_beat = out_o;
      end
    end
  end

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    void'($urandom(88793));
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    psum_valid_i = 1'b0;
    psum_i       = '0;
    norm_valid_i = 1'b0;
    norm_i       = '0;
    bp_en        = 1'b0;
    held         = 1'b0;
    n_stream     = 0;
    n_beats      = 0;
    ptr          = 0;
    for (int i = 0; i < accq_pkg::NUM_ACC; i++) begin
      model[i] = '0;
    end
    repeat (5) @(negedge clk);
    rst_ni = 1'b1;
    @(negedge clk);

    // reset state and then an all-zero beat
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("cmd_ready_o", cmd_ready_o, 1'b1);
    do_streamout();

    do_clear();
    do_accumulate(20, 0);
    do_streamout();

    // sums and addresses carry on without a clear
    do_accumulate(5, 2);
    do_accumulate(0, 0);
    do_accumulate(6, 0);
    do_streamout();

    // saturating and in-range normquant passes
    do_clear();
    do_accumulate(8, 1);
    do_normquant(1'b1);
    do_streamout();
    do_clear();
    do_accumulate(12, 2);
    do_normquant(1'b0);
    do_streamout();

    bp_en = 1'b1;
    repeat (6) begin
      do_accumulate(int'($urandom_range(9, 1)), 0);
      do_streamout();
    end
    bp_en = 1'b0;
    @(negedge clk);

    if (exp_q.size() == 0 && n_beats == n_stream) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_failure("number of out beats does not match the streamout commands");
    end
  end

endmodule

//--- accq.f
src/accq_pkg.sv
src/accq_fifo.sv
src/accq_bank.sv
src/accq_normquant.sv
src/accq_ctrl.sv
src/accq_top.sv
testbench/tb_clock.sv
testbench/accq_tb.sv

//--- Makefile
# Verilator simulation of the accumulator bank

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module accq_tb -f accq.f -Mdir obj_dir
	./obj_dir/Vaccq_tb | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
